// ==== dma_rd_stimulus.txt ====
# columns: start byte address (hex), length in bytes (hex)
# one descriptor per line
0100 0040
0203 0010
0300 000b
0411 0001
0522 0003
0ff4 0020
1ffd 0009
0601 00c5
0800 0100
2a37 0052
3000 0004
3fe2 0071
07fe 0002

// ==== src.f ====
dma_rd_pkg.sv
dma_rd_req_gen.sv
dma_rd_cmd_fifo.sv
dma_rd_align.sv
dma_rd_out_skid.sv
dma_rd_top.sv
tb_axi_mem.sv
tb_dma_rd.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --assert --timescale 1ns/1ps -j 0
TOP       ?= tb_dma_rd
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^No errors$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== tb_dma_rd.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_dma_rd;

    localparam int MAX_BURST_LEN = 16;
    localparam int CMD_FIFO_DEPTH = 4;
    localparam int SW = dma_rd_pkg::STRB_WIDTH;
    localparam int PAGE = dma_rd_pkg::PAGE_BYTES;

    logic aclk;
    logic aresetn;
    dma_rd_pkg::rd_desc_t desc;
    logic desc_valid;
    logic desc_ready;
    dma_rd_pkg::ar_req_t ar;
    logic ar_valid;
    logic ar_ready;
    logic [dma_rd_pkg::DATA_WIDTH-1:0] r_data;
    logic r_last;
    logic r_valid;
    logic r_ready;
    dma_rd_pkg::axis_beat_t m_axis;
    logic m_axis_valid;
    logic m_axis_ready;
    logic status_valid;
    logic ar_gap;
    logic r_gap;

    int desc_addr [$];
    int desc_len [$];
    int ndesc;
    int cycle_limit;
    int cycle_count;
    logic [31:0] lfsr_state;

    // scoreboard position that only the monitor updates
    int out_idx;
    int out_beat;
    int out_byte;
    int ar_idx;
    int ar_word;
    int ar_words_left;
    int status_count;
    logic status_prev = 1'b0;
    logic stalled = 1'b0;
    dma_rd_pkg::axis_beat_t stalled_beat;

    int data_errors;
    int keep_errors;
    int burst_errors;
    int status_errors;
    int stall_errors;
    int other_errors;

    dma_rd_top #(
        .MAX_BURST_LEN (MAX_BURST_LEN),
        .CMD_FIFO_DEPTH(CMD_FIFO_DEPTH)
    ) dut (
        .aclk        (aclk),
        .aresetn     (aresetn),
        .desc        (desc),
        .desc_valid  (desc_valid),
        .desc_ready  (desc_ready),
        .ar          (ar),
        .ar_valid    (ar_valid),
        .ar_ready    (ar_ready),
        .r_data      (r_data),
        .r_last      (r_last),
        .r_valid     (r_valid),
        .r_ready     (r_ready),
        .m_axis      (m_axis),
        .m_axis_valid(m_axis_valid),
        .m_axis_ready(m_axis_ready),
        .status_valid(status_valid)
    );

    tb_axi_mem mem_model (
        .aclk    (aclk),
        .ar      (ar),
        .ar_valid(ar_valid),
        .ar_ready(ar_ready),
        .r_data  (r_data),
        .r_last  (r_last),
        .r_valid (r_valid),
        .r_ready (r_ready),
        .ar_gap  (ar_gap),
        .r_gap   (r_gap)
    );

    function automatic logic [7:0] pattern_byte(input int addr);
        logic [15:0] a;
        a = 16'(addr);
        return a[7:0] ^ a[15:8];
    endfunction

    // taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic random_bit();
        lfsr_state = lfsr_next(lfsr_state);
        return lfsr_state[0];
    endfunction

    function automatic int error_total();
        return data_errors + keep_errors + burst_errors + status_errors + stall_errors
            + other_errors;
    endfunction

    task automatic print_error_counts();
        $display("Error counts: data %0d, keep/last %0d, burst %0d, status %0d, stall %0d, other %0d",
            data_errors, keep_errors, burst_errors, status_errors, stall_errors, other_errors);
    endtask

    task automatic expect_reset_outputs(input string phase);
        assert (!ar_valid && !r_ready && !m_axis_valid && !status_valid && desc_ready) else begin
            other_errors++;
            $display("Mismatch at %0t: outputs %s, ar_valid %b r_ready %b m_axis_valid %b %s %b",
                $time, phase, ar_valid, r_ready, m_axis_valid, "status_valid", status_valid);
            $display("    desc_ready %b", desc_ready);
        end
    endtask

    task automatic score_stream_beat();
        int nbeats;
        int rem;
        logic last_exp;
        logic [SW-1:0] keep_exp;
        logic [7:0] exp_byte;
        if (stalled) begin
            assert (m_axis_valid && m_axis == stalled_beat) else begin
                stall_errors++;
                $display("At %0t the stream beat changed or vanished while tready was low",
                    $time);
            end
        end
        stalled = m_axis_valid && !m_axis_ready;
        stalled_beat = m_axis;
        if (m_axis_valid && m_axis_ready) begin
            assert (out_idx < ndesc) else begin
                keep_errors++;
                $display("At %0t a stream beat arrived after every descriptor had ended", $time);
            end
            if (out_idx < ndesc) begin
                nbeats = (desc_len[out_idx] + SW - 1) / SW;
                rem = desc_len[out_idx] % SW;
                last_exp = out_beat == nbeats - 1;
                keep_exp = (last_exp && rem != 0) ? SW'((1 << rem) - 1) : {SW{1'b1}};
                assert (m_axis.keep == keep_exp && m_axis.last == last_exp) else begin
                    keep_errors++;
                    $display("Mismatch at %0t: descriptor %0d beat %0d keep %b last %b, want %b %b",
                        $time, out_idx, out_beat, m_axis.keep, m_axis.last, keep_exp, last_exp);
                end
                for (int i = 0; i < SW; i++) begin
                    if (keep_exp[i]) begin
                        exp_byte = pattern_byte(desc_addr[out_idx] + out_byte);
                        assert (m_axis.data[8*i +: 8] == exp_byte) else begin
                            data_errors++;
                            $display("Mismatch at %0t: descriptor %0d byte %0d is %h, want %h",
                                $time, out_idx, out_byte, m_axis.data[8*i +: 8], exp_byte);
                        end
                        out_byte++;
                    end
                end
                out_beat++;
                if (last_exp) begin
                    out_idx++;
                    out_beat = 0;
                    out_byte = 0;
                end
            end
        end
    endtask

    task automatic audit_burst();
        int beats;
        int start_word;
        int end_byte;
        if (ar_valid && ar_ready) begin
            assert (ar_idx < ndesc) else begin
                burst_errors++;
                $display("At %0t a burst was requested with no descriptor left", $time);
            end
            if (ar_idx < ndesc) begin
                if (ar_words_left == 0) begin
                    ar_word = desc_addr[ar_idx] / SW;
                    ar_words_left = (desc_addr[ar_idx] + desc_len[ar_idx] - 1) / SW - ar_word + 1;
                end
                beats = int'(ar.len) + 1;
                start_word = int'(ar.addr) / SW;
                end_byte = (start_word + beats) * SW - 1;
                assert (start_word == ar_word && beats <= ar_words_left) else begin
                    burst_errors++;
                    $display("Mismatch at %0t: burst word %h len %0d, want word %h within %0d",
                        $time, start_word, beats, ar_word, ar_words_left);
                end
                assert (beats <= MAX_BURST_LEN && (start_word * SW) / PAGE == end_byte / PAGE)
                else begin
                    burst_errors++;
                    $display("At %0t the burst at %h of %0d beats is too long or crosses 4 KB",
                        $time, ar.addr, beats);
                end
                ar_word = start_word + beats;
                ar_words_left -= beats;
                if (ar_words_left <= 0) begin
                    ar_idx++;
                    ar_words_left = 0;
                end
            end
        end
    endtask

    task automatic count_status_pulse();
        if (status_valid) begin
            assert (status_count < ndesc && !status_prev) else begin
                status_errors++;
                $display("At %0t a status pulse came with no descriptor left or ran long", $time);
            end
            status_count++;
        end
        status_prev = status_valid;
    endtask

    initial begin
        aclk = 1'b0;
        forever begin
            #5 aclk = ~aclk;
        end
    end

    // stall bits for tready, arready and rvalid gaps
    initial begin
        lfsr_state = 32'he26c_a01b;
        m_axis_ready = 1'b0;
        ar_gap = 1'b0;
        r_gap = 1'b0;
        forever begin
            @(negedge aclk);
            m_axis_ready = random_bit();
            ar_gap = random_bit();
            r_gap = random_bit();
        end
    end

    always @(posedge aclk) begin
        if (aresetn) begin
            score_stream_beat();
            audit_burst();
            count_status_pulse();
        end
    end

    initial begin
        cycle_count = 0;
        while (cycle_limit == 0 || cycle_count < cycle_limit) begin
            @(posedge aclk);
            cycle_count++;
        end
        $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
        print_error_counts();
        $display("Errors found");
        $finish;
    end

    initial begin
        int fd;
        int code;
        int a;
        int l;
        int total_len;
        string line;
        aresetn = 1'b0;
        desc = '0;
        desc_valid = 1'b0;
        total_len = 0;
        fd = $fopen("dma_rd_stimulus.txt", "r");
        if (fd == 0) begin
            other_errors++;
            $display("Could not open the stimulus file dma_rd_stimulus.txt");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                code = $fgets(line, fd);
                if (code > 0 && line.len() > 0 && line[0] != "#") begin
                    if ($sscanf(line, "%h %h", a, l) == 2) begin
                        desc_addr.push_back(a);
                        desc_len.push_back(l);
                        total_len += l;
                    end
                end
            end
            $fclose(fd);
        end
        ndesc = desc_addr.size();
        if (ndesc == 0) begin
            other_errors++;
            $display("The stimulus file gave no descriptors");
        end
        cycle_limit = 200 + 8 * total_len;

        repeat (3) @(negedge aclk);
        expect_reset_outputs("during reset");
        aresetn = 1'b1;
        @(negedge aclk);
        expect_reset_outputs("after reset");

        // desc_ready only moves on rising edges, so a high value here means the next edge takes it
        for (int i = 0; i < ndesc; i++) begin
            desc.addr = 16'(desc_addr[i]);
            desc.len = 20'(desc_len[i]);
            desc_valid = 1'b1;
            while (!desc_ready) begin
                @(negedge aclk);
            end
            @(negedge aclk);
        end
        desc_valid = 1'b0;

        while (out_idx < ndesc || status_count < ndesc) begin
            @(negedge aclk);
        end
        // let any stray beat or pulse show up
        repeat (20) @(negedge aclk);
        assert (status_count == ndesc && ar_idx == ndesc && out_idx == ndesc) else begin
            other_errors++;
            $display("Mismatch at %0t: %0d status, %0d fetched, %0d streamed, of %0d",
                $time, status_count, ar_idx, out_idx, ndesc);
        end

        print_error_counts();
        if (error_total() == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb_axi_mem.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_axi_mem (
    input  wire                               aclk,
    input  wire dma_rd_pkg::ar_req_t          ar,
    input  wire                               ar_valid,
    output logic                              ar_ready,
    output logic [dma_rd_pkg::DATA_WIDTH-1:0] r_data,
    output logic                              r_last,
    output logic                              r_valid,
    input  wire                               r_ready,
    input  wire                               ar_gap,
    input  wire                               r_gap
);

    localparam int SW = dma_rd_pkg::STRB_WIDTH;

    logic [15:0] addr_q [$];
    logic [7:0]  len_q [$];
    logic [15:0] beat_addr;
    logic [7:0]  beats_left;
    logic        busy;

    logic ar_fire = 1'b0;
    logic r_fire = 1'b0;
    logic ar_gap_seen = 1'b0;
    logic r_gap_seen = 1'b0;
    dma_rd_pkg::ar_req_t ar_seen;

    // byte at address a is a[7:0] xor a[15:8]
    function automatic logic [dma_rd_pkg::DATA_WIDTH-1:0] word_at(input logic [15:0] addr);
        logic [dma_rd_pkg::DATA_WIDTH-1:0] w;
        logic [15:0] a;
        w = '0;
        for (int i = 0; i < SW; i++) begin
            a = addr + 16'(i);
            w[8*i +: 8] = a[7:0] ^ a[15:8];
        end
        return w;
    endfunction

    // handshakes seen on the rising edge are acted on at the next falling edge
    always @(posedge aclk) begin
        ar_fire <= ar_valid && ar_ready;
        r_fire <= r_valid && r_ready;
        ar_seen <= ar;
        ar_gap_seen <= ar_gap;
        r_gap_seen <= r_gap;
    end

    initial begin
        ar_ready = 1'b0;
        r_valid = 1'b0;
        r_last = 1'b0;
        r_data = '0;
        busy = 1'b0;
        beat_addr = '0;
        beats_left = '0;
        forever begin
            @(negedge aclk);
            if (ar_fire) begin
                // bursts start on the word that holds the address
                addr_q.push_back({ar_seen.addr[15:2], 2'b00});
                len_q.push_back(ar_seen.len);
            end
            if (r_fire) begin
                r_valid = 1'b0;
                if (beats_left == 8'd0) begin
                    busy = 1'b0;
                end else begin
                    beat_addr = beat_addr + 16'(SW);
                    beats_left = beats_left - 8'd1;
                end
            end
            if (!busy && addr_q.size() > 0) begin
                beat_addr = addr_q.pop_front();
                beats_left = len_q.pop_front();
                busy = 1'b1;
            end
            if (busy && !r_valid && !r_gap_seen) begin
                r_valid = 1'b1;
                r_last = beats_left == 8'd0;
                r_data = word_at(beat_addr);
            end
            ar_ready = !ar_gap_seen;
        end
    end

endmodule

`default_nettype wire

// ==== dma_rd_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module dma_rd_top #(
    parameter int MAX_BURST_LEN = 16,
    parameter int CMD_FIFO_DEPTH = 4
) (
    input  wire                   aclk,
    input  wire                   aresetn,
    input  wire dma_rd_pkg::rd_desc_t desc,
    input  wire                   desc_valid,
    output logic                  desc_ready,
    output dma_rd_pkg::ar_req_t   ar,
    output logic                  ar_valid,
    input  wire                   ar_ready,
    input  wire [dma_rd_pkg::DATA_WIDTH-1:0] r_data,
    input  wire                   r_last,
    input  wire                   r_valid,
    output logic                  r_ready,
    output dma_rd_pkg::axis_beat_t m_axis,
    output logic                  m_axis_valid,
    input  wire                   m_axis_ready,
    output logic                  status_valid
);

    // wide enough for every burst of all commands in flight
    localparam int OST_WIDTH = dma_rd_pkg::CYCLE_COUNT_WIDTH + $clog2(CMD_FIFO_DEPTH + 2);

    dma_rd_pkg::rd_cmd_t    cmd_in;
    dma_rd_pkg::rd_cmd_t    cmd_out;
    dma_rd_pkg::axis_beat_t beat;

    logic cmd_in_valid;
    logic cmd_in_ready;
    logic cmd_out_valid;
    logic cmd_out_ready;
    logic beat_valid;
    logic skid_ready_early;
    logic skid_ready_reg;
    logic ar_fire;
    logic r_end;
    logic [OST_WIDTH-1:0] bursts_open;

    assign ar_fire = ar_valid && ar_ready;
    assign r_end = r_valid && r_ready && r_last;

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            skid_ready_reg <= 1'b0;
            bursts_open <= '0;
        end else begin
            skid_ready_reg <= skid_ready_early;
            bursts_open <= bursts_open + OST_WIDTH'(ar_fire) - OST_WIDTH'(r_end);
        end
    end

    dma_rd_req_gen #(
        .MAX_BURST_LEN(MAX_BURST_LEN)
    ) u_req_gen (
        .aclk        (aclk),
        .aresetn     (aresetn),
        .desc        (desc),
        .desc_valid  (desc_valid),
        .desc_ready  (desc_ready),
        .cmd_in      (cmd_in),
        .cmd_in_valid(cmd_in_valid),
        .cmd_in_ready(cmd_in_ready),
        .ar          (ar),
        .ar_valid    (ar_valid),
        .ar_ready    (ar_ready)
    );

    dma_rd_cmd_fifo #(
        .CMD_FIFO_DEPTH(CMD_FIFO_DEPTH)
    ) u_cmd_fifo (
        .aclk         (aclk),
        .aresetn      (aresetn),
        .cmd_in       (cmd_in),
        .cmd_in_valid (cmd_in_valid),
        .cmd_in_ready (cmd_in_ready),
        .cmd_out      (cmd_out),
        .cmd_out_valid(cmd_out_valid),
        .cmd_out_ready(cmd_out_ready)
    );

    dma_rd_align u_align (
        .aclk            (aclk),
        .aresetn         (aresetn),
        .cmd_out         (cmd_out),
        .cmd_out_valid   (cmd_out_valid),
        .cmd_out_ready   (cmd_out_ready),
        .r_data          (r_data),
        .r_valid         (r_valid),
        .r_ready         (r_ready),
        .beat            (beat),
        .beat_valid      (beat_valid),
        .skid_ready_early(skid_ready_early),
        .status_valid    (status_valid)
    );

    dma_rd_out_skid u_out_skid (
        .aclk            (aclk),
        .aresetn         (aresetn),
        .beat            (beat),
        .beat_valid      (beat_valid),
        .skid_ready_reg  (skid_ready_reg),
        .skid_ready_early(skid_ready_early),
        .m_axis          (m_axis),
        .m_axis_valid    (m_axis_valid),
        .m_axis_ready    (m_axis_ready)
    );

    // the memory may only close a burst that decode has issued
    a_rlast_has_burst: assert property (@(posedge aclk) disable iff (!aresetn)
        r_end |-> bursts_open != '0 || ar_fire);

endmodule

`default_nettype wire

// ==== dma_rd_out_skid.sv ====
`timescale 1ns/1ps
`default_nettype none

module dma_rd_out_skid (
    input  wire                   aclk,
    input  wire                   aresetn,
    input  wire dma_rd_pkg::axis_beat_t beat,
    input  wire                   beat_valid,
    input  wire                   skid_ready_reg,
    output logic                  skid_ready_early,
    output dma_rd_pkg::axis_beat_t m_axis,
    output logic                  m_axis_valid,
    input  wire                   m_axis_ready
);

    dma_rd_pkg::axis_beat_t temp_beat;

    logic out_valid_next;
    logic temp_valid, temp_valid_next;
    logic to_out;
    logic to_temp;
    logic temp_to_out;

    // ready next cycle unless the temp slot could end up full
    assign skid_ready_early = m_axis_ready || (!temp_valid && (!m_axis_valid || !beat_valid));

    always_comb begin
        out_valid_next = m_axis_valid;
        temp_valid_next = temp_valid;
        to_out = 1'b0;
        to_temp = 1'b0;
        temp_to_out = 1'b0;

        if (skid_ready_reg) begin
            if (m_axis_ready || !m_axis_valid) begin
                out_valid_next = beat_valid;
                to_out = 1'b1;
            end else begin
                temp_valid_next = beat_valid;
                to_temp = 1'b1;
            end
        end else if (m_axis_ready) begin
            out_valid_next = temp_valid;
            temp_valid_next = 1'b0;
            temp_to_out = 1'b1;
        end
    end

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            m_axis_valid <= 1'b0;
            temp_valid <= 1'b0;
        end else begin
            m_axis_valid <= out_valid_next;
            temp_valid <= temp_valid_next;
        end
    end

    always_ff @(posedge aclk) begin
        if (to_out) begin
            m_axis <= beat;
        end else if (temp_to_out) begin
            m_axis <= temp_beat;
        end
        if (to_temp) begin
            temp_beat <= beat;
        end
    end

    a_axis_stable: assert property (@(posedge aclk) disable iff (!aresetn)
        m_axis_valid && !m_axis_ready |=> m_axis_valid && $stable(m_axis));

endmodule

`default_nettype wire

// ==== dma_rd_align.sv ====
`timescale 1ns/1ps
`default_nettype none

module dma_rd_align (
    input  wire                  aclk,
    input  wire                  aresetn,
    input  wire dma_rd_pkg::rd_cmd_t cmd_out,
    input  wire                  cmd_out_valid,
    output logic                 cmd_out_ready,
    input  wire [dma_rd_pkg::DATA_WIDTH-1:0] r_data,
    input  wire                  r_valid,
    output logic                 r_ready,
    output dma_rd_pkg::axis_beat_t beat,
    output logic                 beat_valid,
    input  wire                  skid_ready_early,
    output logic                 status_valid
);

    localparam int DW = dma_rd_pkg::DATA_WIDTH;
    localparam int SW = dma_rd_pkg::STRB_WIDTH;
    localparam int OW = dma_rd_pkg::OFFSET_WIDTH;
    localparam int CW = dma_rd_pkg::CYCLE_COUNT_WIDTH;

    typedef enum logic {
        ST_IDLE,
        ST_READ
    } state_t;

    state_t state, state_next;

    logic [OW-1:0] offset_reg, offset_next;
    logic [OW-1:0] last_off_reg, last_off_next;
    logic [CW-1:0] in_count_reg, in_count_next;
    logic [CW-1:0] out_count_reg, out_count_next;
    logic in_active_reg, in_active_next;
    logic bubble_reg, bubble_next;
    logic first_reg, first_next;
    logic out_last_reg, out_last_next;
    logic status_next;
    logic r_ready_next;
    logic ready_reg;
    logic save_en;
    logic [DW-1:0] save_data;
    logic [2*DW-1:0] joined;

    // current word goes above the saved one and both shift down by the start offset
    assign joined = {r_data, save_data} >> ((SW - offset_reg) * 8);

    always_comb begin
        state_next = state;
        offset_next = offset_reg;
        last_off_next = last_off_reg;
        in_count_next = in_count_reg;
        out_count_next = out_count_reg;
        in_active_next = in_active_reg;
        bubble_next = bubble_reg;
        first_next = first_reg;
        out_last_next = out_last_reg;
        status_next = 1'b0;
        r_ready_next = 1'b0;
        cmd_out_ready = 1'b0;
        save_en = 1'b0;
        beat.data = joined[DW-1:0];
        beat.keep = '1;
        beat.last = 1'b0;
        beat_valid = 1'b0;

        case (state)
            ST_IDLE: begin
                offset_next = cmd_out.offset;
                last_off_next = cmd_out.last_cycle_offset;
                in_count_next = cmd_out.input_cycle_count;
                out_count_next = cmd_out.output_cycle_count;
                bubble_next = cmd_out.bubble;
                out_last_next = cmd_out.output_cycle_count == '0;
                in_active_next = 1'b1;
                first_next = 1'b1;
                if (cmd_out_valid) begin
                    cmd_out_ready = 1'b1;
                    r_ready_next = skid_ready_early;
                    state_next = ST_READ;
                end
            end
            ST_READ: begin
                r_ready_next = skid_ready_early && in_active_reg;
                // step once a word arrives or freely when all input is in
                if (ready_reg && ((r_ready && r_valid) || !in_active_reg)) begin
                    save_en = r_ready && r_valid;
                    if (in_active_reg) begin
                        in_count_next = in_count_reg - 1'b1;
                        in_active_next = in_count_reg != '0;
                    end
                    bubble_next = 1'b0;
                    first_next = 1'b0;
                    if (first_reg && bubble_reg) begin
                        r_ready_next = skid_ready_early && in_active_next;
                    end else begin
                        out_count_next = out_count_reg - 1'b1;
                        out_last_next = out_count_next == '0;
                        beat_valid = 1'b1;
                        if (out_last_reg) begin
                            if (last_off_reg != '0) begin
                                beat.keep = {SW{1'b1}} >> (SW - last_off_reg);
                            end
                            beat.last = 1'b1;
                            status_next = 1'b1;
                            r_ready_next = 1'b0;
                            state_next = ST_IDLE;
                        end else begin
                            r_ready_next = skid_ready_early && in_active_next;
                        end
                    end
                end
            end
            default: state_next = ST_IDLE;
        endcase
    end

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            state <= ST_IDLE;
            status_valid <= 1'b0;
            r_ready <= 1'b0;
            ready_reg <= 1'b0;
        end else begin
            state <= state_next;
            status_valid <= status_next;
            r_ready <= r_ready_next;
            ready_reg <= skid_ready_early;
        end
    end

    always_ff @(posedge aclk) begin
        offset_reg <= offset_next;
        last_off_reg <= last_off_next;
        in_count_reg <= in_count_next;
        out_count_reg <= out_count_next;
        in_active_reg <= in_active_next;
        bubble_reg <= bubble_next;
        first_reg <= first_next;
        out_last_reg <= out_last_next;
        if (save_en) begin
            save_data <= r_data;
        end
    end

    a_no_rready_idle: assert property (@(posedge aclk) disable iff (!aresetn)
        state == ST_IDLE |-> !r_ready);

endmodule

`default_nettype wire

// ==== dma_rd_cmd_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module dma_rd_cmd_fifo #(
    parameter int CMD_FIFO_DEPTH = 4
) (
    input  wire                 aclk,
    input  wire                 aresetn,
    input  wire dma_rd_pkg::rd_cmd_t cmd_in,
    input  wire                 cmd_in_valid,
    output logic                cmd_in_ready,
    output dma_rd_pkg::rd_cmd_t cmd_out,
    output logic                cmd_out_valid,
    input  wire                 cmd_out_ready
);

    localparam int PTR_WIDTH = (CMD_FIFO_DEPTH > 1) ? $clog2(CMD_FIFO_DEPTH) : 1;
    localparam int CNT_WIDTH = $clog2(CMD_FIFO_DEPTH + 1);
    localparam logic [PTR_WIDTH-1:0] LAST_SLOT = PTR_WIDTH'(CMD_FIFO_DEPTH - 1);

    dma_rd_pkg::rd_cmd_t mem [CMD_FIFO_DEPTH];

    logic [PTR_WIDTH-1:0] wr_ptr;
    logic [PTR_WIDTH-1:0] rd_ptr;
    logic [CNT_WIDTH-1:0] count;
    logic push;
    logic pop;

    assign cmd_in_ready = count != CNT_WIDTH'(CMD_FIFO_DEPTH);
    assign cmd_out_valid = count != '0;
    assign cmd_out = mem[rd_ptr];

    assign push = cmd_in_valid && cmd_in_ready;
    assign pop = cmd_out_valid && cmd_out_ready;

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == LAST_SLOT) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == LAST_SLOT) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + CNT_WIDTH'(push) - CNT_WIDTH'(pop);
        end
    end

    always_ff @(posedge aclk) begin
        if (push) begin
            mem[wr_ptr] <= cmd_in;
        end
    end

    // decode only offers a command while it sees room
    a_no_push_full: assert property (@(posedge aclk) disable iff (!aresetn)
        cmd_in_valid |-> cmd_in_ready);

endmodule

`default_nettype wire

// ==== dma_rd_req_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module dma_rd_req_gen #(
    parameter int MAX_BURST_LEN = 16
) (
    input  wire                  aclk,
    input  wire                  aresetn,
    input  wire dma_rd_pkg::rd_desc_t desc,
    input  wire                  desc_valid,
    output logic                 desc_ready,
    output dma_rd_pkg::rd_cmd_t  cmd_in,
    output logic                 cmd_in_valid,
    input  wire                  cmd_in_ready,
    output dma_rd_pkg::ar_req_t  ar,
    output logic                 ar_valid,
    input  wire                  ar_ready
);

    localparam int AW = dma_rd_pkg::ADDR_WIDTH;
    localparam int LW = dma_rd_pkg::LEN_WIDTH;
    localparam int OW = dma_rd_pkg::OFFSET_WIDTH;
    localparam int BS = dma_rd_pkg::BURST_SIZE;
    localparam int CW = dma_rd_pkg::CYCLE_COUNT_WIDTH;
    localparam int PAGE_BITS = $clog2(dma_rd_pkg::PAGE_BYTES);
    localparam int MAX_BURST_BYTES = MAX_BURST_LEN * dma_rd_pkg::STRB_WIDTH;

    typedef enum logic {
        ST_IDLE,
        ST_START
    } state_t;

    state_t state, state_next;

    logic [AW-1:0] addr_reg, addr_next;
    logic [LW-1:0] remain_reg, remain_next;
    logic [LW-1:0] page_room;
    logic [LW-1:0] max_room;
    logic [LW-1:0] chunk;
    logic [LW:0]   burst_bytes;
    logic [LW:0]   in_bytes;
    logic [LW-1:0] out_bytes;

    dma_rd_pkg::ar_req_t ar_next;
    logic ar_valid_next;

    // command fields come straight from the descriptor
    assign in_bytes = {1'b0, desc.len} + (LW + 1)'(desc.addr[OW-1:0]) - 1'b1;
    assign out_bytes = desc.len - 1'b1;

    always_comb begin
        cmd_in.offset = OW'(dma_rd_pkg::STRB_WIDTH - desc.addr[OW-1:0]);
        cmd_in.last_cycle_offset = desc.len[OW-1:0];
        cmd_in.bubble = desc.addr[OW-1:0] != '0;
        cmd_in.input_cycle_count = in_bytes[LW:BS];
        cmd_in.output_cycle_count = CW'(out_bytes[LW-1:BS]);
    end

    assign desc_ready = (state == ST_IDLE) && cmd_in_ready;
    assign cmd_in_valid = desc_valid && desc_ready;

    // room to the page end and to the longest burst, both from the unaligned address
    assign page_room = LW'(dma_rd_pkg::PAGE_BYTES) - LW'(addr_reg[PAGE_BITS-1:0]);
    assign max_room = LW'(MAX_BURST_BYTES) - LW'(addr_reg[OW-1:0]);

    always_comb begin
        chunk = (remain_reg < max_room) ? remain_reg : max_room;
        if (chunk > page_room) begin
            chunk = page_room;
        end
    end

    assign burst_bytes = {1'b0, chunk} + (LW + 1)'(addr_reg[OW-1:0]) - 1'b1;

    always_comb begin
        state_next = state;
        addr_next = addr_reg;
        remain_next = remain_reg;
        ar_next = ar;
        ar_valid_next = ar_valid && !ar_ready;

        case (state)
            ST_IDLE: begin
                if (cmd_in_valid) begin
                    addr_next = desc.addr;
                    remain_next = desc.len;
                    state_next = ST_START;
                end
            end
            ST_START: begin
                // next burst is cut only once the previous one is gone
                if (!ar_valid) begin
                    ar_next.addr = addr_reg;
                    ar_next.len = 8'(burst_bytes >> BS);
                    ar_valid_next = 1'b1;
                    addr_next = addr_reg + AW'(chunk);
                    remain_next = remain_reg - chunk;
                    if (remain_next == '0) begin
                        state_next = ST_IDLE;
                    end
                end
            end
            default: state_next = ST_IDLE;
        endcase
    end

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            state <= ST_IDLE;
            ar_valid <= 1'b0;
        end else begin
            state <= state_next;
            ar_valid <= ar_valid_next;
        end
    end

    always_ff @(posedge aclk) begin
        addr_reg <= addr_next;
        remain_reg <= remain_next;
        ar <= ar_next;
    end

    a_desc_len_nonzero: assert property (@(posedge aclk) disable iff (!aresetn)
        cmd_in_valid |-> desc.len != '0);

    a_ar_stable: assert property (@(posedge aclk) disable iff (!aresetn)
        ar_valid && !ar_ready |=> ar_valid && $stable(ar));

endmodule

`default_nettype wire

// ==== dma_rd_pkg.sv ====
`default_nettype none

package dma_rd_pkg;

    // memory side geometry
    localparam int ADDR_WIDTH = 16;
    localparam int DATA_WIDTH = 32;
    localparam int STRB_WIDTH = DATA_WIDTH / 8;
    localparam int OFFSET_WIDTH = $clog2(STRB_WIDTH);
    localparam int BURST_SIZE = $clog2(STRB_WIDTH);

    // descriptor length and the beat counters derived from it
    localparam int LEN_WIDTH = 20;
    localparam int CYCLE_COUNT_WIDTH = LEN_WIDTH - BURST_SIZE + 1;

    // bursts must not cross this boundary
    localparam int PAGE_BYTES = 4096;

    typedef struct packed {
        logic [ADDR_WIDTH-1:0] addr;
        logic [LEN_WIDTH-1:0]  len;
    } rd_desc_t;

    // alignment facts of one descriptor, handed from decode to execute
    typedef struct packed {
        logic [OFFSET_WIDTH-1:0]      offset;
        logic [OFFSET_WIDTH-1:0]      last_cycle_offset;
        logic                         bubble;
        logic [CYCLE_COUNT_WIDTH-1:0] input_cycle_count;
        logic [CYCLE_COUNT_WIDTH-1:0] output_cycle_count;
    } rd_cmd_t;

    typedef struct packed {
        logic [ADDR_WIDTH-1:0] addr;
        logic [7:0]            len;
    } ar_req_t;

    typedef struct packed {
        logic [DATA_WIDTH-1:0] data;
        logic [STRB_WIDTH-1:0] keep;
        logic                  last;
    } axis_beat_t;

endpackage

`default_nettype wire
